// ==== common/panel_pkg.sv ====
/*
 * panel geometry, pixel and framebuffer address types,
 * and the HUB75 pin bundle driven by the scanner
 */
`default_nettype none

package panel_pkg;

    localparam int PANEL_WIDTH  = 8;  // columns
    localparam int PANEL_HEIGHT = 4;  // rows, top and bottom half together
    localparam int ROW_PAIRS    = 2;  // rows per half = scan rows
    localparam int COLOR_BITS   = 2;  // bit-planes per channel

    typedef logic [$clog2(PANEL_WIDTH)-1:0]              col_addr_t;
    typedef logic [$clog2(ROW_PAIRS)-1:0]                row_addr_t;
    typedef logic [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0] fb_addr_t;
    typedef logic [3*COLOR_BITS-1:0]                     pixel_t;  // red, green, blue
    typedef logic [$clog2(COLOR_BITS)-1:0]               plane_t;
    typedef logic [2:0]                                  rgb_t;    // bit 2 red, bit 0 blue
    typedef logic [COLOR_BITS-1:0]                       brightness_mask_t;

    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    // pins of one HUB75 connector
    typedef struct packed {
        rgb_t      rgb_top;
        rgb_t      rgb_bottom;
        row_addr_t row_addr;
        logic      clk_pixel;
        logic      latch;
        logic      oe_n;  // low = leds on
    } hub75_t;

endpackage

`default_nettype wire

// ==== common/link_pkg.sv ====
/*
 * serial link constants, command opcodes and decoder states
 */
`default_nettype none

package link_pkg;

    localparam int UART_DATA_BITS = 8;  // 8N1 framing

    typedef logic [UART_DATA_BITS-1:0] byte_t;

    localparam byte_t CMD_PIXEL             = 8'h50;  // 'P' addr data
    localparam byte_t CMD_RGB_ENABLE        = 8'h45;  // 'E' mask, bits 2:0 = r g b
    localparam byte_t CMD_BRIGHTNESS_ENABLE = 8'h42;  // 'B' mask, one bit per plane

    typedef enum logic [2:0] {
        IDLE,
        PIXEL_ADDR,
        PIXEL_DATA,
        RGB_MASK,
        BRIGHT_MASK
    } cmd_state_t;

endpackage

`default_nettype wire

// ==== src/uart_rx.sv ====
/*
 * 8N1 serial receiver with two-flop input synchronizer
 */
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic            clk_root,
    input  wire logic            rst_n,
    input  wire logic            rxd,
    output link_pkg::byte_t      rx_byte,
    output logic                 rx_strobe
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam int BIT_W = $clog2(link_pkg::UART_DATA_BITS);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t          state;
    logic               rxd_meta;
    logic               rxd_sync;
    logic [CNT_W-1:0]   clk_cnt;
    logic [BIT_W-1:0]   bit_idx;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;  // idle line is high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            clk_cnt   <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync) state <= RX_START;  // start edge
                end
                RX_START: if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state   <= rxd_sync ? RX_IDLE : RX_DATA;  // glitch, back to idle
                end
                RX_DATA: if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == BIT_W'(link_pkg::UART_DATA_BITS - 1)) state <= RX_STOP;
                end
                RX_STOP: if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    rx_strobe <= rxd_sync;  // bad stop bit drops the frame
                    state     <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first, shifted in at bit centres
    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            rx_byte <= {rxd_sync, rx_byte[link_pkg::UART_DATA_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== control/command_decoder.sv ====
/*
 * byte command decoder: framebuffer pixel writes and mask updates
 */
`timescale 1ns/100ps
`default_nettype none

module command_decoder (
    input  wire logic                clk_root,
    input  wire logic                rst_n,
    input  wire link_pkg::byte_t     rx_byte,
    input  wire logic                rx_strobe,
    output logic                     fb_write_en,
    output panel_pkg::fb_addr_t      fb_write_addr,
    output panel_pkg::pixel_t        fb_write_data,
    output logic                     cfg_write_rgb,
    output logic                     cfg_write_bright,
    output link_pkg::byte_t          cfg_data
);

    localparam int ADDR_W = $bits(panel_pkg::fb_addr_t);
    localparam int PIX_W  = $bits(panel_pkg::pixel_t);

    link_pkg::cmd_state_t state;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state            <= link_pkg::IDLE;
            fb_write_en      <= 1'b0;
            cfg_write_rgb    <= 1'b0;
            cfg_write_bright <= 1'b0;
        end else begin
            fb_write_en      <= 1'b0;  // all writes are single pulses
            cfg_write_rgb    <= 1'b0;
            cfg_write_bright <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    link_pkg::IDLE: begin
                        case (rx_byte)
                            link_pkg::CMD_PIXEL:             state <= link_pkg::PIXEL_ADDR;
                            link_pkg::CMD_RGB_ENABLE:        state <= link_pkg::RGB_MASK;
                            link_pkg::CMD_BRIGHTNESS_ENABLE: state <= link_pkg::BRIGHT_MASK;
                            default:                         state <= link_pkg::IDLE;
                        endcase
                    end
                    link_pkg::PIXEL_ADDR: state <= link_pkg::PIXEL_DATA;
                    link_pkg::PIXEL_DATA: begin
                        fb_write_en <= 1'b1;
                        state       <= link_pkg::IDLE;
                    end
                    link_pkg::RGB_MASK: begin
                        cfg_write_rgb <= 1'b1;
                        state         <= link_pkg::IDLE;
                    end
                    link_pkg::BRIGHT_MASK: begin
                        cfg_write_bright <= 1'b1;
                        state            <= link_pkg::IDLE;
                    end
                    default: state <= link_pkg::IDLE;
                endcase
            end
        end
    end

    // operand bytes, captured alongside the state moves above
    always_ff @(posedge clk_root) begin
        if (rx_strobe) begin
            if (state == link_pkg::PIXEL_ADDR) fb_write_addr <= rx_byte[ADDR_W-1:0];
            if (state == link_pkg::PIXEL_DATA) fb_write_data <= rx_byte[PIX_W-1:0];
            cfg_data <= rx_byte;  // only consumed with a cfg pulse
        end
    end

endmodule

`default_nettype wire

// ==== control/panel_config_regs.sv ====
/*
 * colour-enable and brightness-enable mask registers
 */
`timescale 1ns/100ps
`default_nettype none

module panel_config_regs (
    input  wire logic                  clk_root,
    input  wire logic                  rst_n,
    input  wire logic                  cfg_write_rgb,
    input  wire logic                  cfg_write_bright,
    input  wire link_pkg::byte_t       cfg_data,
    output panel_pkg::rgb_t            rgb_enable,
    output panel_pkg::brightness_mask_t brightness_enable
);

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            rgb_enable        <= '1;  // everything visible out of reset
            brightness_enable <= '1;
        end else begin
            if (cfg_write_rgb) begin
                rgb_enable <= cfg_data[$bits(panel_pkg::rgb_t)-1:0];
            end
            if (cfg_write_bright) begin
                brightness_enable <= cfg_data[panel_pkg::COLOR_BITS-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/framebuffer_ram.sv ====
/*
 * pixel memory, one write port and one registered read port
 */
`timescale 1ns/100ps
`default_nettype none

module framebuffer_ram (
    input  wire logic                 clk_root,
    input  wire logic                 write_en,
    input  wire panel_pkg::fb_addr_t  write_addr,
    input  wire panel_pkg::pixel_t    write_data,
    input  wire logic                 rd_en,
    input  wire panel_pkg::fb_addr_t  rd_addr,
    output panel_pkg::pixel_t         rd_data
);

    localparam int DEPTH = panel_pkg::PANEL_WIDTH * panel_pkg::PANEL_HEIGHT;

    panel_pkg::pixel_t mem [DEPTH];

    always_ff @(posedge clk_root) begin
        if (write_en) mem[write_addr] <= write_data;
    end

    // one cycle read latency
    always_ff @(posedge clk_root) begin
        if (rd_en) rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== scan/frame_fetch.sv ====
/*
 * pixel pair fetch for the scanner, top row then bottom row,
 * answered over a four-phase req/ack handshake
 */
`timescale 1ns/100ps
`default_nettype none

module frame_fetch (
    input  wire logic                   clk_root,
    input  wire logic                   rst_n,
    input  wire logic                   col_req,
    input  wire panel_pkg::col_addr_t   col_addr,
    input  wire panel_pkg::row_addr_t   row_addr,
    output logic                        col_ack,
    output panel_pkg::pixel_pair_t      pixel_pair,
    output logic                        rd_en,
    output panel_pkg::fb_addr_t         rd_addr,
    input  wire panel_pkg::pixel_t      rd_data
);

    localparam int ADDR_W = $bits(panel_pkg::fb_addr_t);

    typedef enum logic [2:0] {F_IDLE, F_TOP, F_BOTTOM, F_CAPTURE, F_ACK} fetch_state_t;

    fetch_state_t        state;
    panel_pkg::fb_addr_t top_addr;
    panel_pkg::fb_addr_t bottom_addr;

    // bottom half sits ROW_PAIRS rows further down
    assign top_addr    = ADDR_W'(row_addr * panel_pkg::PANEL_WIDTH + col_addr);
    assign bottom_addr = ADDR_W'((row_addr + panel_pkg::ROW_PAIRS) * panel_pkg::PANEL_WIDTH
                                 + col_addr);

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state   <= F_IDLE;
            rd_en   <= 1'b0;
            col_ack <= 1'b0;
        end else begin
            case (state)
                F_IDLE: if (col_req) begin
                    rd_en <= 1'b1;
                    state <= F_TOP;
                end
                F_TOP:    state <= F_BOTTOM;  // ram takes top address
                F_BOTTOM: begin
                    rd_en <= 1'b0;
                    state <= F_CAPTURE;
                end
                F_CAPTURE: begin
                    col_ack <= 1'b1;
                    state   <= F_ACK;
                end
                F_ACK: if (!col_req) begin
                    col_ack <= 1'b0;
                    state   <= F_IDLE;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == F_IDLE)    rd_addr <= top_addr;
        if (state == F_TOP)     rd_addr <= bottom_addr;
        if (state == F_BOTTOM)  pixel_pair.top    <= rd_data;
        if (state == F_CAPTURE) pixel_pair.bottom <= rd_data;
    end

endmodule

`default_nettype wire

// ==== scan/matrix_scan.sv ====
/*
 * HUB75 scanner with column shift, row latch and weighted bit-plane on time
 */
`timescale 1ns/100ps
`default_nettype none

module matrix_scan #(
    parameter int ON_TIME_BASE = 4
) (
    input  wire logic                         clk_root,
    input  wire logic                         rst_n,
    input  wire panel_pkg::rgb_t              rgb_enable,
    input  wire panel_pkg::brightness_mask_t  brightness_enable,
    output logic                              col_req,
    output panel_pkg::col_addr_t              col_addr,
    output panel_pkg::row_addr_t              row_addr,
    input  wire logic                         col_ack,
    input  wire panel_pkg::pixel_pair_t       pixel_pair,
    output panel_pkg::hub75_t                 panel
);

    localparam int MAX_ON = ON_TIME_BASE << (panel_pkg::COLOR_BITS - 1);  // longest plane
    localparam int ON_W   = $clog2(MAX_ON + 1);

    typedef enum logic [2:0] {S_REQUEST, S_WAIT_ACK, S_CLOCK, S_LATCH, S_DISPLAY} scan_state_t;

    scan_state_t          state;
    panel_pkg::plane_t    plane;
    logic [ON_W-1:0]      on_cnt;

    // channel bits of one plane after both masks
    function automatic panel_pkg::rgb_t plane_bits(panel_pkg::pixel_t px,
                                                   panel_pkg::plane_t p,
                                                   panel_pkg::rgb_t rgb_en,
                                                   panel_pkg::brightness_mask_t br_en);
        panel_pkg::rgb_t bits;
        for (int ch = 0; ch < $bits(panel_pkg::rgb_t); ch++) begin
            bits[ch] = px[ch*panel_pkg::COLOR_BITS + p] & rgb_en[ch];
        end
        return bits & {$bits(panel_pkg::rgb_t){br_en[p]}};
    endfunction

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state      <= S_REQUEST;
            col_req    <= 1'b0;
            col_addr   <= '0;
            row_addr   <= '0;
            plane      <= '0;
            on_cnt     <= '0;
            panel      <= '0;
            panel.oe_n <= 1'b1;  // dark until the first plane
        end else begin
            panel.clk_pixel <= 1'b0;
            panel.latch     <= 1'b0;
            case (state)
                S_REQUEST: if (!col_ack) begin  // previous ack gone
                    col_req <= 1'b1;
                    state   <= S_WAIT_ACK;
                end
                S_WAIT_ACK: if (col_ack) begin
                    col_req          <= 1'b0;
                    panel.rgb_top    <= plane_bits(pixel_pair.top, plane,
                                                   rgb_enable, brightness_enable);
                    panel.rgb_bottom <= plane_bits(pixel_pair.bottom, plane,
                                                   rgb_enable, brightness_enable);
                    state            <= S_CLOCK;
                end
                S_CLOCK: begin
                    panel.clk_pixel <= 1'b1;  // data already stable for a cycle
                    col_addr        <= col_addr + 1'b1;
                    if (col_addr == panel_pkg::col_addr_t'(panel_pkg::PANEL_WIDTH - 1)) begin
                        col_addr <= '0;
                        state    <= S_LATCH;
                    end else begin
                        state <= S_REQUEST;
                    end
                end
                S_LATCH: begin
                    panel.latch    <= 1'b1;
                    panel.row_addr <= row_addr;
                    on_cnt         <= ON_W'(ON_TIME_BASE << plane);
                    state          <= S_DISPLAY;
                end
                S_DISPLAY: begin
                    if (on_cnt != '0) begin
                        panel.oe_n <= 1'b0;
                        on_cnt     <= on_cnt - 1'b1;
                    end else begin
                        panel.oe_n <= 1'b1;
                        plane      <= plane + 1'b1;
                        // next row once all planes of this one are shown
                        if (plane == panel_pkg::plane_t'(panel_pkg::COLOR_BITS - 1)) begin
                            plane    <= '0;
                            row_addr <= (row_addr == panel_pkg::row_addr_t'(
                                         panel_pkg::ROW_PAIRS - 1)) ? '0 : row_addr + 1'b1;
                        end
                        state <= S_REQUEST;
                    end
                end
                default: state <= S_REQUEST;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/led_matrix_top.sv ====
/*
 * LED matrix driver top: uart, command decoder, masks, framebuffer, fetch, scan
 */
`timescale 1ns/100ps
`default_nettype none

module led_matrix_top #(
    parameter int CLKS_PER_BIT = 8,
    parameter int ON_TIME_BASE = 4
) (
    input  wire logic          clk_root,
    input  wire logic          rst_n,
    input  wire logic          uart_rxd,
    output panel_pkg::hub75_t  panel
);

    link_pkg::byte_t              rx_byte;
    logic                         rx_strobe;
    logic                         fb_write_en;
    panel_pkg::fb_addr_t          fb_write_addr;
    panel_pkg::pixel_t            fb_write_data;
    logic                         cfg_write_rgb;
    logic                         cfg_write_bright;
    link_pkg::byte_t              cfg_data;
    panel_pkg::rgb_t              rgb_enable;
    panel_pkg::brightness_mask_t  brightness_enable;
    logic                         col_req;
    logic                         col_ack;
    panel_pkg::col_addr_t         col_addr;
    panel_pkg::row_addr_t         row_addr;
    panel_pkg::pixel_pair_t       pixel_pair;
    logic                         rd_en;
    panel_pkg::fb_addr_t          rd_addr;
    panel_pkg::pixel_t            rd_data;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk_root, .rst_n, .rxd(uart_rxd), .rx_byte, .rx_strobe
    );

    command_decoder u_command_decoder (
        .clk_root, .rst_n, .rx_byte, .rx_strobe,
        .fb_write_en, .fb_write_addr, .fb_write_data,
        .cfg_write_rgb, .cfg_write_bright, .cfg_data
    );

    panel_config_regs u_panel_config_regs (
        .clk_root, .rst_n, .cfg_write_rgb, .cfg_write_bright, .cfg_data,
        .rgb_enable, .brightness_enable
    );

    framebuffer_ram u_framebuffer_ram (
        .clk_root,
        .write_en(fb_write_en), .write_addr(fb_write_addr), .write_data(fb_write_data),
        .rd_en, .rd_addr, .rd_data
    );

    frame_fetch u_frame_fetch (
        .clk_root, .rst_n, .col_req, .col_addr, .row_addr, .col_ack,
        .pixel_pair, .rd_en, .rd_addr, .rd_data
    );

    matrix_scan #(.ON_TIME_BASE(ON_TIME_BASE)) u_matrix_scan (
        .clk_root, .rst_n, .rgb_enable, .brightness_enable,
        .col_req, .col_addr, .row_addr, .col_ack, .pixel_pair, .panel
    );

endmodule

`default_nettype wire

// ==== tb/led_matrix_checker.sv ====
/*
 * concurrent assertions on the fetch handshake and the panel pins,
 * bound into the scanner
 */
`timescale 1ns/100ps
`default_nettype none

module led_matrix_checker (
    input wire logic              clk_root,
    input wire logic              rst_n,
    input wire logic              col_req,
    input wire logic              col_ack,
    input wire panel_pkg::hub75_t panel
);

    // four-phase handshake
    req_held_until_ack: assert property (@(posedge clk_root) disable iff (!rst_n)
        col_req && !col_ack |=> col_req)
        else $error("col_req dropped before col_ack rose");

    ack_only_with_req: assert property (@(posedge clk_root) disable iff (!rst_n)
        $rose(col_ack) |-> col_req)
        else $error("col_ack rose without a pending col_req");

    no_req_during_ack: assert property (@(posedge clk_root) disable iff (!rst_n)
        $rose(col_req) |-> !col_ack)
        else $error("col_req rose while col_ack was still high");

    // shifting and latching only while dark
    no_shift_while_lit: assert property (@(posedge clk_root) disable iff (!rst_n)
        !(panel.clk_pixel && !panel.oe_n))
        else $error("clk_pixel high while oe_n low");

    no_latch_while_lit: assert property (@(posedge clk_root) disable iff (!rst_n)
        !(panel.latch && !panel.oe_n))
        else $error("latch high while oe_n low");

endmodule

// the scanner sees both handshake lines and drives the panel
bind matrix_scan led_matrix_checker u_checker (
    .clk_root, .rst_n, .col_req, .col_ack, .panel
);

`default_nettype wire

// ==== tb/tb_led_matrix.sv ====
/*
 * testbench for the LED matrix driver: clock, reset, uart driver, LFSR pixel data,
 * stimulus table, panel monitor and checks
 */
`timescale 1ns/100ps
`default_nettype none

module tb_led_matrix;

    localparam int CLKS_PER_BIT = 8;
    localparam int ON_TIME_BASE = 4;
    localparam int CLK_PERIOD   = 100;
    localparam int WIDTH        = panel_pkg::PANEL_WIDTH;
    localparam int NUM_PIXELS   = panel_pkg::PANEL_WIDTH * panel_pkg::PANEL_HEIGHT;
    localparam int NUM_TESTS    = 5;
    localparam int LATCHES_PER_FRAME = panel_pkg::ROW_PAIRS * panel_pkg::COLOR_BITS;

    // watchdog budget, generous per column and per frame
    localparam int FRAMES_PER_TEST  = 3 * NUM_PIXELS + 4 + 3;
    localparam int BITS_PER_FRAME   = 12;  // start, 8 data, stop, 2 idle
    localparam int LATCH_CYCLES     = WIDTH * 10 + 4
                                      + (ON_TIME_BASE << (panel_pkg::COLOR_BITS - 1));
    localparam int SCAN_PASS_CYCLES = LATCHES_PER_FRAME * LATCH_CYCLES;
    localparam int TEST_CYCLES      = FRAMES_PER_TEST * BITS_PER_FRAME * CLKS_PER_BIT
                                      + 8 * SCAN_PASS_CYCLES;
    localparam int WATCHDOG_NS      = NUM_TESTS * TEST_CYCLES * 2 * CLK_PERIOD;

    typedef struct packed {
        panel_pkg::rgb_t             rgb_mask;
        panel_pkg::brightness_mask_t bright_mask;
        logic                        garbage;  // junk opcode plus a bad-stop frame
    } stim_t;

    localparam stim_t STIM [NUM_TESTS] = '{
        '{3'b111, 2'b11, 1'b0},
        '{3'b101, 2'b11, 1'b0},
        '{3'b111, 2'b10, 1'b0},
        '{3'b011, 2'b01, 1'b0},
        '{3'b110, 2'b11, 1'b1}
    };
    string test_names [NUM_TESTS] = '{"all_on", "rgb_101", "bright_10",
                                      "rgb_011_bright_01", "garbage_frames"};

    logic              clk_root = 1'b0;
    logic              rst_n;
    logic              uart_rxd;
    panel_pkg::hub75_t panel;

    // monitor state
    panel_pkg::rgb_t      shift_top [WIDTH];
    panel_pkg::rgb_t      shift_bot [WIDTH];
    panel_pkg::rgb_t      shown_top [WIDTH];
    panel_pkg::rgb_t      shown_bot [WIDTH];
    panel_pkg::row_addr_t shown_row;
    int                   col_idx;
    int                   latch_count;
    int                   on_cycles;
    int                   on_time_last;
    int                   on_done_count;
    logic                 oe_was_low;
    string                cur_test = "reset";

    logic [31:0]          lfsr_state;
    panel_pkg::pixel_t    model_px [NUM_PIXELS];

    led_matrix_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .ON_TIME_BASE(ON_TIME_BASE)) u_dut (
        .clk_root, .rst_n, .uart_rxd, .panel
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk_root = ~clk_root;
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // lit bits of one column for a given plane and mask setting
    function automatic panel_pkg::rgb_t expected_rgb(panel_pkg::pixel_t px, int plane,
                                                    panel_pkg::rgb_t rgb_mask,
                                                    panel_pkg::brightness_mask_t bright_mask);
        panel_pkg::rgb_t bits;
        bits[2] = px[2 * panel_pkg::COLOR_BITS + plane];  // red
        bits[1] = px[panel_pkg::COLOR_BITS + plane];
        bits[0] = px[plane];                              // blue
        if (!bright_mask[plane]) bits = '0;
        return bits & rgb_mask;
    endfunction

    task automatic drive_bit(input logic value);
        @(negedge clk_root);
        uart_rxd = value;
        repeat (CLKS_PER_BIT - 1) @(negedge clk_root);
    endtask

    task automatic send_frame(input link_pkg::byte_t data, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);  // lsb first
        end
        drive_bit(stop_bit);
        drive_bit(1'b1);
        drive_bit(1'b1);  // idle gap, lets a false start after a bad stop die out
    endtask

    task automatic load_pixels();
        logic [31:0] value;
        for (int a = 0; a < NUM_PIXELS; a++) begin
            draw_bits($bits(panel_pkg::pixel_t), value);
            model_px[a] = panel_pkg::pixel_t'(value);
            send_frame(link_pkg::CMD_PIXEL, 1'b1);
            send_frame(link_pkg::byte_t'(a), 1'b1);
            send_frame(link_pkg::byte_t'(value), 1'b1);
        end
    endtask

    task automatic check_idle_outputs();
        assert (panel.oe_n && !panel.latch && !panel.clk_pixel) else begin
            $display("Fail %s idle panel: expected oe_n 1 latch 0 clk_pixel 0, actual %b %b %b",
                     cur_test, panel.oe_n, panel.latch, panel.clk_pixel);
            abort_run();
        end
    endtask

    task automatic skip_latches(input int count);
        int target;
        @(posedge clk_root);
        target = latch_count + count;
        while (latch_count < target) @(posedge clk_root);
    endtask

    // waits for the next latch and its display period, then compares
    task automatic check_next_latch(input int idx);
        int              target;
        int              k;
        int              row;
        int              plane;
        panel_pkg::rgb_t exp_top;
        panel_pkg::rgb_t exp_bot;
        @(posedge clk_root);
        target = latch_count + 1;
        while (on_done_count < target) @(posedge clk_root);
        k     = target - 1;
        row   = (k / 2) % panel_pkg::ROW_PAIRS;
        plane = k % 2;
        assert (int'(shown_row) == row) else begin
            $display("Fail %s latch %0d row_addr: expected %0d, actual %0d",
                     test_names[idx], k, row, shown_row);
            abort_run();
        end
        assert (on_time_last == (ON_TIME_BASE << plane)) else begin
            $display("Fail %s latch %0d on time: expected %0d, actual %0d",
                     test_names[idx], k, ON_TIME_BASE << plane, on_time_last);
            abort_run();
        end
        for (int c = 0; c < WIDTH; c++) begin
            exp_top = expected_rgb(model_px[row * WIDTH + c], plane,
                                   STIM[idx].rgb_mask, STIM[idx].bright_mask);
            exp_bot = expected_rgb(model_px[(row + panel_pkg::ROW_PAIRS) * WIDTH + c], plane,
                                   STIM[idx].rgb_mask, STIM[idx].bright_mask);
            assert (shown_top[c] == exp_top && shown_bot[c] == exp_bot) else begin
                $display("Fail %s latch %0d col %0d: expected %b/%b, actual %b/%b",
                         test_names[idx], k, c, exp_top, exp_bot, shown_top[c], shown_bot[c]);
                abort_run();
            end
        end
    endtask

    // panel monitor, samples on the falling edge
    always @(negedge clk_root) begin
        if (!rst_n) begin
            col_idx       = 0;
            latch_count   = 0;
            on_cycles     = 0;
            on_time_last  = 0;
            on_done_count = 0;
            oe_was_low    = 1'b0;
        end else begin
            if (panel.clk_pixel) begin
                assert (col_idx < WIDTH) else begin
                    $display("more than %0d columns were shifted before a latch", WIDTH);
                    abort_run();
                end
                shift_top[col_idx] = panel.rgb_top;
                shift_bot[col_idx] = panel.rgb_bottom;
                col_idx++;
            end
            if (panel.latch) begin
                assert (col_idx == WIDTH) else begin
                    $display("a latch came after %0d columns instead of %0d", col_idx, WIDTH);
                    abort_run();
                end
                shown_top = shift_top;
                shown_bot = shift_bot;
                shown_row = panel.row_addr;
                col_idx   = 0;
                on_cycles = 0;
                latch_count++;
            end else if (!panel.oe_n) begin
                on_cycles++;
            end
            if (panel.oe_n && oe_was_low) begin  // end of a display period
                on_time_last = on_cycles;
                on_done_count++;
            end
            oe_was_low = !panel.oe_n;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        lfsr_state = 32'hd41dbdb3;
        rst_n      = 1'b0;
        uart_rxd   = 1'b1;
        repeat (3) @(negedge clk_root);
        check_idle_outputs();
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk_root);
            check_idle_outputs();
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = test_names[t];
            load_pixels();
            send_frame(link_pkg::CMD_RGB_ENABLE, 1'b1);
            send_frame(link_pkg::byte_t'(STIM[t].rgb_mask), 1'b1);
            send_frame(link_pkg::CMD_BRIGHTNESS_ENABLE, 1'b1);
            send_frame(link_pkg::byte_t'(STIM[t].bright_mask), 1'b1);
            if (STIM[t].garbage) begin
                send_frame(8'ha5, 1'b1);                     // no such opcode
                send_frame(link_pkg::CMD_RGB_ENABLE, 1'b0);  // dropped, low stop bit
                send_frame(8'h00, 1'b1);                     // stray mask byte, ignored
            end
            skip_latches(LATCHES_PER_FRAME);  // first frame may mix old and new data
            repeat (LATCHES_PER_FRAME) check_next_latch(t);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/panel_pkg.sv
common/link_pkg.sv
src/uart_rx.sv
control/command_decoder.sv
control/panel_config_regs.sv
src/framebuffer_ram.sv
scan/frame_fetch.sv
scan/matrix_scan.sv
src/led_matrix_top.sv
tb/led_matrix_checker.sv
tb/tb_led_matrix.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the LED matrix testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_led_matrix -f vlog.f \
    && ./obj_dir/Vtb_led_matrix | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
